//--- lsu_assertions.sv
`timescale 1ns/1ns

module lsu_assertions (
    input logic           clock,
    input logic           reset,
    input logic           awvalid, awready, wvalid, wready, arvalid, arready,
    input logic           bready, rready, mem_ready,
    input lsu_pkg::word_t awaddr, araddr, wdata
);

    // valid held with stable payload until ready
    aw_held: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before awready");
    w_held: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid dropped or wdata changed before wready");
    ar_held: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    // one transaction at a time
    no_overlap: assert property (@(posedge clock) disable iff (reset)
        (wvalid || bready || rready) |=> !(awvalid || arvalid))
        else $error("address valid raised before the previous transaction ended");

    ready_one_cycle: assert property (@(posedge clock) disable iff (reset)
        mem_ready |=> !mem_ready)
        else $error("mem_ready high two cycles in a row");

    quiet_in_reset: assert property (@(posedge clock)
        reset |=> !(awvalid || wvalid || bready || arvalid || rready || mem_ready))
        else $error("handshake output high while in reset");

endmodule

bind lsu_top lsu_assertions i_assertions (
    .clock(clock), .reset(reset),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .arvalid(arvalid), .arready(arready), .bready(bready), .rready(rready),
    .mem_ready(mem_ready), .awaddr(awaddr), .araddr(araddr), .wdata(wdata)
);

//--- lsu_ctrl.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu_ctrl (
    input  logic                  clock,
    input  logic                  reset,

    // execute side
    input  logic                  mem_valid,
    input  logic                  mem_wen,
    input  logic                  mem_unsigned,
    input  lsu_pkg::word_t        mem_addr,
    input  lsu_pkg::word_t        mem_wdata,
    input  lsu_pkg::access_size_t mem_size,

    // axi handshake inputs
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    input  logic                  arready,
    input  logic                  rvalid,

    input  lsu_pkg::word_t        load_data,    // from load aligner

    output logic                  mem_ready,
    output lsu_pkg::word_t        mem_rdata,

    // axi handshake outputs
    output logic                  awvalid,
    output logic                  wvalid,
    output logic                  bready,
    output logic                  arvalid,
    output logic                  rready,

    // captured request
    output lsu_pkg::word_t        req_addr,
    output lsu_pkg::word_t        req_wdata,
    output lsu_pkg::access_size_t req_size,
    output logic                  req_unsigned,
    output lsu_pkg::id_t          txn_id
);

    lsu_pkg::lsu_state_t state;
    lsu_pkg::lsu_state_t next_state;
    logic                accept;    // request taken this cycle

    assign accept = (state == lsu_pkg::st_idle) && mem_valid;

    // state and id counter
    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= lsu_pkg::st_idle;
            txn_id <= '0;    // first accepted request gets id 1
        end else begin
            state <= next_state;
            if (accept) begin
                txn_id <= txn_id + `LSU_ID_W'(1);    // wraps at 16
            end
        end
    end

    // request payload, held for the whole transaction
    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr     <= mem_addr;
            req_wdata    <= mem_wdata;
            req_size     <= mem_size;
            req_unsigned <= mem_unsigned;
        end
    end

    // each phase waits for its partner signal
    always_comb begin
        next_state = state;
        case (state)
            lsu_pkg::st_idle: begin
                if (mem_valid) begin
                    next_state = mem_wen ? lsu_pkg::st_write_addr : lsu_pkg::st_read_addr;
                end
            end
            lsu_pkg::st_write_addr: begin
                if (awready) begin
                    next_state = lsu_pkg::st_write_data;
                end
            end
            lsu_pkg::st_write_data: begin
                if (wready) begin
                    next_state = lsu_pkg::st_write_resp;
                end
            end
            lsu_pkg::st_write_resp: begin
                if (bvalid) begin
                    next_state = lsu_pkg::st_idle;    // any bresp completes
                end
            end
            lsu_pkg::st_read_addr: begin
                if (arready) begin
                    next_state = lsu_pkg::st_read_data;
                end
            end
            lsu_pkg::st_read_data: begin
                if (rvalid) begin
                    next_state = lsu_pkg::st_idle;
                end
            end
            default: next_state = lsu_pkg::st_idle;    // stray encodings
        endcase
    end

    // valid/ready straight from the state
    assign awvalid = (state == lsu_pkg::st_write_addr);
    assign wvalid  = (state == lsu_pkg::st_write_data);
    assign bready  = (state == lsu_pkg::st_write_resp);
    assign arvalid = (state == lsu_pkg::st_read_addr);
    assign rready  = (state == lsu_pkg::st_read_data);

    // one cycle completion pulse on the response beat
    assign mem_ready = (bready && bvalid) || (rready && rvalid);
    assign mem_rdata = load_data;    // only meaningful with rvalid

endmodule

//--- lsu_load_align.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu_load_align (
    input  lsu_pkg::word_t        req_addr,
    input  lsu_pkg::access_size_t req_size,
    input  logic                  req_unsigned,
    input  lsu_pkg::word_t        rdata,
    output lsu_pkg::word_t        load_data
);

    logic [1:0]     offset;
    lsu_pkg::word_t shifted;      // addressed lane moved down to bit 0
    logic [7:0]     lane_byte;
    logic [15:0]    lane_half;
    logic           fill_byte;    // extension bit for byte loads
    logic           fill_half;    // extension bit for half loads

    assign offset    = req_addr[1:0];
    assign shifted   = rdata >> {offset, 3'b000};
    assign lane_byte = shifted[7:0];
    assign lane_half = shifted[15:0];

    // unsigned loads fill with zero
    assign fill_byte = lane_byte[7] & ~req_unsigned;
    assign fill_half = lane_half[15] & ~req_unsigned;

    always_comb begin
        load_data = '0;    // misaligned or unknown size returns zero
        case (req_size)
            lsu_pkg::size_byte: begin
                load_data = {{(`LSU_XLEN-8){fill_byte}}, lane_byte};
            end
            lsu_pkg::size_half: begin
                if (!offset[0]) begin    // same rule as sh
                    load_data = {{(`LSU_XLEN-16){fill_half}}, lane_half};
                end
            end
            lsu_pkg::size_word: begin
                if (offset == 2'b00) begin
                    load_data = rdata;    // full word, no extension
                end
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

//--- lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;    // data or address word
    typedef logic [`LSU_STRB_W-1:0] strb_t;    // write strobe, bit per byte
    typedef logic [`LSU_ID_W-1:0]   id_t;      // axi id on aw and ar

    // access size in axi axsize encoding
    typedef enum logic [`LSU_SIZE_W-1:0] {
        size_byte = 3'd0,    // lb lbu sb
        size_half = 3'd1,    // lh lhu sh
        size_word = 3'd2     // lw sw
    } access_size_t;         // codes 3 to 7 are unknown sizes

    // one state per axi channel phase
    typedef enum logic [2:0] {
        st_idle       = 3'd0,    // waiting for mem_valid
        st_write_addr = 3'd1,    // awvalid up
        st_write_data = 3'd2,    // wvalid up
        st_write_resp = 3'd3,    // bready up
        st_read_addr  = 3'd4,    // arvalid up
        st_read_data  = 3'd5     // rready up
    } lsu_state_t;

endpackage

//--- lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// datapath widths
`define LSU_XLEN    32                  // address and data word
`define LSU_STRB_W  (`LSU_XLEN / 8)     // one strobe bit per byte lane
`define LSU_ID_W    4                   // axi transaction id

// axi field widths
`define LSU_SIZE_W  3                   // axsize
`define LSU_LEN_W   8                   // axlen
`define LSU_BURST_W 2                   // axburst

// fixed burst fields for single beat transfers
`define LSU_AXI_BURST_INCR  2'd1        // incr burst code
`define LSU_AXI_LEN_SINGLE  8'd0        // one beat means len 0

`endif

//--- lsu_store_align.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu_store_align (
    input  lsu_pkg::word_t        req_addr,
    input  lsu_pkg::word_t        req_wdata,
    input  lsu_pkg::access_size_t req_size,
    output lsu_pkg::strb_t        wstrb,
    output lsu_pkg::word_t        wdata
);

    logic [1:0] offset;        // byte offset in the word
    logic [4:0] lane_shift;    // offset in bits

    assign offset     = req_addr[1:0];
    assign lane_shift = {offset, 3'b000};

    always_comb begin
        wstrb = '0;           // misaligned or unknown size writes nothing
        wdata = req_wdata;    // unshifted when strobe is zero
        case (req_size)
            lsu_pkg::size_byte: begin
                // any offset is fine for a byte
                wstrb = lsu_pkg::strb_t'(1) << offset;
                wdata = {{(`LSU_XLEN-8){1'b0}}, req_wdata[7:0]} << lane_shift;
            end
            lsu_pkg::size_half: begin
                if (!offset[0]) begin    // offset 0 or 2
                    wstrb = lsu_pkg::strb_t'(2'b11) << offset;
                    wdata = {{(`LSU_XLEN-16){1'b0}}, req_wdata[15:0]} << lane_shift;
                end
            end
            lsu_pkg::size_word: begin
                if (offset == 2'b00) begin
                    wstrb = '1;    // all lanes, data as is
                end
            end
            default: begin
                wstrb = '0;
            end
        endcase
    end

endmodule

//--- lsu_top.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu_top (
    input  logic                    clock,
    input  logic                    reset,

    // execute side
    input  logic                    mem_valid,
    input  lsu_pkg::word_t          mem_addr,
    input  lsu_pkg::word_t          mem_wdata,
    input  logic                    mem_wen,
    input  lsu_pkg::access_size_t   mem_size,
    input  logic                    mem_unsigned,
    output logic                    mem_ready,
    output lsu_pkg::word_t          mem_rdata,

    // aw channel
    input  logic                    awready,
    output logic                    awvalid,
    output lsu_pkg::word_t          awaddr,
    output lsu_pkg::id_t            awid,
    output logic [`LSU_LEN_W-1:0]   awlen,
    output lsu_pkg::access_size_t   awsize,
    output logic [`LSU_BURST_W-1:0] awburst,

    // w channel
    input  logic                    wready,
    output logic                    wvalid,
    output lsu_pkg::word_t          wdata,
    output lsu_pkg::strb_t          wstrb,
    output logic                    wlast,

    // b channel
    output logic                    bready,
    input  logic                    bvalid,

    // ar channel
    input  logic                    arready,
    output logic                    arvalid,
    output lsu_pkg::word_t          araddr,
    output lsu_pkg::id_t            arid,
    output logic [`LSU_LEN_W-1:0]   arlen,
    output lsu_pkg::access_size_t   arsize,
    output logic [`LSU_BURST_W-1:0] arburst,

    // r channel
    output logic                    rready,
    input  logic                    rvalid,
    input  lsu_pkg::word_t          rdata
);

    lsu_pkg::word_t        req_addr;
    lsu_pkg::word_t        req_wdata;
    lsu_pkg::access_size_t req_size;
    logic                  req_unsigned;
    lsu_pkg::id_t          txn_id;
    lsu_pkg::word_t        load_data;    // aligned and extended read data

    lsu_ctrl i_ctrl (
        .clock        (clock),
        .reset        (reset),
        .mem_valid    (mem_valid),
        .mem_wen      (mem_wen),
        .mem_unsigned (mem_unsigned),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_size     (mem_size),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .load_data    (load_data),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .awvalid      (awvalid),
        .wvalid       (wvalid),
        .bready       (bready),
        .arvalid      (arvalid),
        .rready       (rready),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .txn_id       (txn_id)
    );

    lsu_store_align i_store_align (
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_size  (req_size),
        .wstrb     (wstrb),
        .wdata     (wdata)
    );

    lsu_load_align i_load_align (
        .req_addr     (req_addr),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .rdata        (rdata),
        .load_data    (load_data)
    );

    // address, size and id shared by both address channels
    assign awaddr = req_addr;
    assign araddr = req_addr;
    assign awsize = req_size;
    assign arsize = req_size;
    assign awid   = txn_id;
    assign arid   = txn_id;

    // single beat incr bursts only
    assign awlen   = `LSU_AXI_LEN_SINGLE;
    assign arlen   = `LSU_AXI_LEN_SINGLE;
    assign awburst = `LSU_AXI_BURST_INCR;
    assign arburst = `LSU_AXI_BURST_INCR;
    assign wlast   = 1'b1;    // every w beat is the last

endmodule

//--- run.sh
#!/bin/sh
# build and run, exit status follows the simulation
verilator --binary --timing --assert --top-module tb_lsu -f src.f -o tb_lsu_sim \
    && ./obj_dir/tb_lsu_sim \
    || exit 1

//--- src.f
+incdir+.
lsu_pkg.sv
lsu_ctrl.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_top.sv
lsu_assertions.sv
tb_lsu.sv

//--- tb_lsu.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module tb_lsu;

    localparam int NUM_REQUESTS = 200;
    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    mem_valid, mem_wen, mem_unsigned, mem_ready;
    lsu_pkg::word_t          mem_addr, mem_wdata, mem_rdata;
    lsu_pkg::access_size_t   mem_size, awsize, arsize;
    logic                    awready, awvalid, wready, wvalid, wlast, bready, bvalid;
    logic                    arready, arvalid, rready, rvalid;
    lsu_pkg::word_t          awaddr, araddr, wdata, rdata;
    lsu_pkg::id_t            awid, arid;
    lsu_pkg::strb_t          wstrb;
    logic [`LSU_LEN_W-1:0]   awlen, arlen;
    logic [`LSU_BURST_W-1:0] awburst, arburst;

    integer       seed = 17;
    lsu_pkg::id_t expected_id;          // id of the request in flight
    int           ready_pulses = 0;     // mem_ready cycles seen so far
    logic [7:0]   mem_model [0:255];    // slave memory, window at 0x8000_0000

    lsu_top i_dut (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        if (mem_ready === 1'b1) begin
            ready_pulses <= ready_pulses + 1;
        end
    end

    function automatic lsu_pkg::word_t next_random();
        next_random = $random(seed);
    endfunction

    // lanes covered by the access, empty when misaligned or size unknown
    function automatic lsu_pkg::strb_t expected_strobe(lsu_pkg::word_t addr, logic [2:0] code);
        int             nbytes;
        int             off;
        lsu_pkg::strb_t s;
        off = int'(addr[1:0]);
        s   = '0;
        case (code)
            3'd0:    nbytes = 1;
            3'd1:    nbytes = 2;
            3'd2:    nbytes = 4;
            default: nbytes = 0;
        endcase
        if (nbytes != 0 && off % nbytes == 0) begin
            for (int i = 0; i < 4; i++) begin
                s[i] = (i >= off) && (i < off + nbytes);
            end
        end
        return s;
    endfunction

    function automatic lsu_pkg::word_t expected_store_data(lsu_pkg::word_t addr, logic [2:0] code,
                                                           lsu_pkg::word_t data);
        lsu_pkg::strb_t s;
        lsu_pkg::word_t result;
        int             off;
        s      = expected_strobe(addr, code);
        off    = int'(addr[1:0]);
        result = '0;
        if (s == '0) begin
            return data;    // nothing written, word goes out as given
        end
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                result[8*i +: 8] = data[8*(i-off) +: 8];
            end
        end
        return result;
    endfunction

    function automatic lsu_pkg::word_t expected_load(lsu_pkg::word_t addr, logic [2:0] code,
                                                     logic uns, lsu_pkg::word_t word);
        lsu_pkg::strb_t s;
        lsu_pkg::word_t val;
        int             off;
        int             nbytes;
        s      = expected_strobe(addr, code);
        off    = int'(addr[1:0]);
        nbytes = $countones(s);
        val    = '0;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                val[8*(i-off) +: 8] = word[8*i +: 8];    // lane down to byte 0
            end
        end
        if (nbytes != 0 && !uns && val[8*nbytes-1]) begin
            for (int j = 8 * nbytes; j < `LSU_XLEN; j++) begin
                val[j] = 1'b1;
            end
        end
        return val;
    endfunction

    function automatic lsu_pkg::word_t model_word(lsu_pkg::word_t addr);
        return {mem_model[{addr[7:2], 2'd3}], mem_model[{addr[7:2], 2'd2}],
                mem_model[{addr[7:2], 2'd1}], mem_model[{addr[7:2], 2'd0}]};
    endfunction

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t actual,
                              input lsu_pkg::word_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_strb(input string name, input lsu_pkg::strb_t actual,
                              input lsu_pkg::strb_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_id(input string name, input lsu_pkg::id_t actual,
                            input lsu_pkg::id_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_bus_idle(input string when);
        if ({awvalid, wvalid, bready, arvalid, rready, mem_ready} !== 6'b0) begin
            report_problem({"AXI valid or ready output high ", when});
        end
    endtask

    task automatic random_stall();
        lsu_pkg::word_t r;
        r = next_random();
        repeat (r[1:0]) @(negedge clock);    // 0 to 3 idle cycles
    endtask

    task automatic finish_beat();
        @(posedge clock);
        @(negedge clock);
    endtask

    task automatic run_request();
        lsu_pkg::word_t r;
        lsu_pkg::word_t exp_data;
        lsu_pkg::word_t word;
        lsu_pkg::strb_t exp_strb;
        logic [2:0]     code;
        int             pulses_before;
        r = next_random();
        if (r[13:10] >= 4'd14) begin
            code = 3'd3 + {1'b0, r[15:14]};    // unknown codes 3..6
        end else begin
            code = 3'(r[13:10] % 4'd3);
        end
        check_bus_idle("before a new request");
        mem_valid    = 1'b1;
        mem_addr     = 32'h8000_0000 | {24'h0, r[7:0]};    // low bits random, often misaligned
        mem_wen      = r[8];
        mem_unsigned = r[9];
        mem_size     = lsu_pkg::access_size_t'(code);
        mem_wdata    = next_random();
        finish_beat();    // unit idle, taken on this edge
        mem_valid     = 1'b0;
        pulses_before = ready_pulses;
        expected_id   = expected_id + lsu_pkg::id_t'(1);
        exp_strb      = expected_strobe(mem_addr, code);
        exp_data      = expected_store_data(mem_addr, code, mem_wdata);
        if (mem_wen) begin
            while (awvalid !== 1'b1) @(negedge clock);
            random_stall();
            check_word("awaddr", awaddr, mem_addr);
            check_word("awsize", lsu_pkg::word_t'(awsize), lsu_pkg::word_t'(code));
            check_id("awid", awid, expected_id);
            check_word("awlen", lsu_pkg::word_t'(awlen), 32'd0);
            check_word("awburst", lsu_pkg::word_t'(awburst), 32'd1);    // incr
            awready = 1'b1;
            finish_beat();
            awready = 1'b0;
            while (wvalid !== 1'b1) @(negedge clock);
            random_stall();
            check_strb("wstrb", wstrb, exp_strb);
            check_word("wdata", wdata, exp_data);
            check_word("wlast", lsu_pkg::word_t'(wlast), 32'd1);
            wready = 1'b1;
            finish_beat();
            wready = 1'b0;
            for (int i = 0; i < 4; i++) begin
                if (exp_strb[i]) begin
                    mem_model[{mem_addr[7:2], 2'(i)}] = exp_data[8*i +: 8];
                end
            end
            while (bready !== 1'b1) @(negedge clock);
            random_stall();
            bvalid = 1'b1;
            #1;
            if (mem_ready !== 1'b1) begin
                report_problem("mem_ready missing in the write response cycle");
            end
            finish_beat();
            bvalid = 1'b0;
        end else begin
            while (arvalid !== 1'b1) @(negedge clock);
            random_stall();
            check_word("araddr", araddr, mem_addr);
            check_word("arsize", lsu_pkg::word_t'(arsize), lsu_pkg::word_t'(code));
            check_id("arid", arid, expected_id);
            check_word("arlen", lsu_pkg::word_t'(arlen), 32'd0);
            check_word("arburst", lsu_pkg::word_t'(arburst), 32'd1);
            arready = 1'b1;
            finish_beat();
            arready = 1'b0;
            while (rready !== 1'b1) @(negedge clock);
            random_stall();
            word   = model_word(mem_addr);    // aligned word from the model
            rdata  = word;
            rvalid = 1'b1;
            #1;
            if (mem_ready !== 1'b1) begin
                report_problem("mem_ready missing in the read data cycle");
            end
            check_word("mem_rdata", mem_rdata, expected_load(mem_addr, code, mem_unsigned, word));
            finish_beat();
            rvalid = 1'b0;
        end
        if (ready_pulses != pulses_before + 1) begin
            report_problem("request did not end with exactly one mem_ready pulse");
        end
    endtask

    initial begin
        reset        = 1'b1;
        mem_valid    = 1'b0;
        mem_wen      = 1'b0;
        mem_unsigned = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_size     = lsu_pkg::size_byte;
        awready      = 1'b0;
        wready       = 1'b0;
        bvalid       = 1'b0;
        arready      = 1'b0;
        rvalid       = 1'b0;
        rdata        = '0;
        expected_id  = '0;
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = 8'(i * 37 + 11);    // odd multiplier, every address distinct
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_bus_idle("after reset");
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            run_request();
        end
        check_bus_idle("after the last request");
        $display(">>> PASS");
        $finish;
    end

    // worst request is well under 20 cycles
    initial begin
        #((NUM_REQUESTS * 20 + RESET_CYCLES) * CLOCK_PERIOD);
        report_problem("run hung, requests did not complete in time");
    end

endmodule
